//--- logic/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// datapath width, pc and instruction words
`define ID_XLEN 32

// exception code width, matches ecode field
`define ID_EXC_W 7

// entries per bank, one slot kept free so usable depth is 3
`define ID_QDEPTH 4

// andi r0,r0,0
`define ID_INST_NOP 32'h0340_0000

// exception codes
`define ID_EXC_NONE 7'h00
`define ID_EXC_SYS 7'h0b   // syscall
`define ID_EXC_BRK 7'h0c   // break
`define ID_EXC_INE 7'h0d   // instruction not exist

`endif

//--- logic/id_pkg.sv
`include "id_macros.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] inst_t;     // raw instruction word
    typedef logic [`ID_XLEN-1:0] addr_t;     // byte address
    typedef logic [`ID_EXC_W-1:0] exc_t;
    typedef logic [4:0] reg_idx_t;           // gpr index
    typedef logic [7:0] uop_t;

    // micro-op codes
    localparam uop_t UOP_NOP     = 8'h00;
    localparam uop_t UOP_ADD     = 8'h01;
    localparam uop_t UOP_SUB     = 8'h02;
    localparam uop_t UOP_ADDI    = 8'h03;
    localparam uop_t UOP_LU12I   = 8'h04;
    localparam uop_t UOP_LD      = 8'h10;
    localparam uop_t UOP_ST      = 8'h11;
    localparam uop_t UOP_BEQ     = 8'h20;
    localparam uop_t UOP_BNE     = 8'h21;
    localparam uop_t UOP_B       = 8'h22;
    localparam uop_t UOP_BL      = 8'h23;
    localparam uop_t UOP_JIRL    = 8'h24;
    localparam uop_t UOP_SYSCALL = 8'h30;
    localparam uop_t UOP_BREAK   = 8'h31;

    // branch category, encoding shared with the predictor
    typedef enum logic [1:0] {
        CAT_NONE = 2'b00,
        CAT_COND = 2'b01,
        CAT_B    = 2'b10,   // b and bl
        CAT_JIRL = 2'b11
    } br_cat_t;

    typedef struct packed {
        inst_t      inst0;
        inst_t      inst1;
        addr_t      pc;          // pc of inst0, bit 2 set means inst0 unused
        addr_t      pc_next;     // pc after the pair
        logic       unknown0;    // predictor has no entry for the word
        logic       unknown1;
        logic       first_jmp;   // inst0 predicted taken, inst1 unused
        exc_t       exc;         // fetch side exception
    } fetch_pair_t;

    typedef struct packed {
        inst_t      inst;
        addr_t      pc;
        addr_t      pc_next;
        exc_t       exc;
    } queue_entry_t;

    typedef struct packed {
        logic               valid;
        uop_t               uop;
        logic [`ID_XLEN-1:0] imm;
        reg_idx_t           rd;
        reg_idx_t           rj;
        reg_idx_t           rk;
        addr_t              pc;
        addr_t              pc_next;
        exc_t               exc;
    } decoded_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        addr_t      target0;
        addr_t      target1;
        br_cat_t    cat0;
        br_cat_t    cat1;
    } predict_fb_t;

endpackage

//--- logic/pre_decoder.sv
module pre_decoder (
    input  id_pkg::inst_t   inst,
    output id_pkg::br_cat_t cat,
    output id_pkg::addr_t   offset
);
    import id_pkg::*;

    logic [5:0] opcode;
    addr_t      offs16;   // beq/bne/jirl style offset
    addr_t      offs26;   // b/bl offset, high part lives in [9:0]

    assign opcode = inst[31:26];

    // word offsets, scaled to bytes and sign extended
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        cat    = CAT_NONE;
        offset = '0;
        case (opcode)
            6'b010011: begin   // jirl, target depends on rj
                cat    = CAT_JIRL;
                offset = offs16;
            end
            6'b010100,
            6'b010101: begin   // b, bl
                cat    = CAT_B;
                offset = offs26;
            end
            // beq bne blt bge bltu bgeu
            6'b010110,
            6'b010111,
            6'b011000,
            6'b011001,
            6'b011010,
            6'b011011: begin
                cat    = CAT_COND;
                offset = offs16;
            end
            default: begin
                cat    = CAT_NONE;   // not a branch
                offset = '0;
            end
        endcase
    end

endmodule

//--- logic/redirect_unit.sv
module redirect_unit (
    input  logic                in_valid,
    input  id_pkg::fetch_pair_t fetch,
    output logic                set_pc,
    output id_pkg::addr_t       redirect_pc,
    output logic                drop1,
    output id_pkg::predict_fb_t feedback,
    output logic                valid0,
    output logic                valid1
);
    import id_pkg::*;

    br_cat_t cat0, cat1;
    addr_t   off0, off1;
    addr_t   target0, target1;
    logic    should_jmp0, should_jmp1;
    logic    jmp0, jmp1;

    pre_decoder u_pre0 (
        .inst   (fetch.inst0),
        .cat    (cat0),
        .offset (off0)
    );

    pre_decoder u_pre1 (
        .inst   (fetch.inst1),
        .cat    (cat1),
        .offset (off1)
    );

    // slot 0 unused when fetch started mid pair
    assign valid0 = ~fetch.pc[2];
    assign valid1 = ~fetch.first_jmp;

    assign target0 = fetch.pc + off0;
    assign target1 = fetch.pc + addr_t'(4) + off1;   // slot 1 sits at pc+4

    // static rule: b/bl taken, conditional taken only backward
    assign should_jmp0 = (cat0 == CAT_B) || ((cat0 == CAT_COND) && off0[31]);
    assign should_jmp1 = (cat1 == CAT_B) || ((cat1 == CAT_COND) && off1[31]);

    assign jmp0 = in_valid && valid0 && fetch.unknown0 && should_jmp0;
    assign jmp1 = in_valid && valid1 && fetch.unknown1 && should_jmp1 && !jmp0;   // older wins

    assign set_pc      = jmp0 || jmp1;
    assign redirect_pc = jmp1 ? target1 : target0;
    assign drop1       = jmp0;   // word after a taken slot 0 is on the wrong path

    // predictor training info, reported for every fetched pair
    assign feedback.valid   = in_valid;
    assign feedback.pc      = fetch.pc;
    assign feedback.target0 = target0;
    assign feedback.target1 = target1;
    assign feedback.cat0    = cat0;
    assign feedback.cat1    = cat1;

endmodule

//--- logic/fetch_queue.sv
`include "id_macros.svh"

module fetch_queue (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 push_valid,
    input  logic                 valid0,
    input  logic                 valid1,
    input  logic                 drop1,
    input  id_pkg::fetch_pair_t  fetch,
    input  logic [1:0]           read_en,   // 00 none, 01 one, 11 two
    output logic                 full,
    output id_pkg::queue_entry_t head0,
    output id_pkg::queue_entry_t head1,
    output logic                 head0_valid,
    output logic                 head1_valid
);
    import id_pkg::*;

    localparam int PTR_W = $clog2(`ID_QDEPTH);

    // two interleaved banks, consecutive words land in alternate banks
    queue_entry_t bank0 [`ID_QDEPTH];
    queue_entry_t bank1 [`ID_QDEPTH];

    logic [PTR_W-1:0] hd0, hd1, tl0, tl1;
    logic [PTR_W-1:0] hd0_inc, hd1_inc, tl0_inc, tl1_inc;
    logic             push_sel;   // bank taking the first queued word
    logic             pop_sel;    // bank holding the oldest word
    logic             empty0, empty1, full0, full1;
    logic             v0, v1;
    logic             push_either, push_both, do_push;
    logic             wr0, wr1;
    logic             pop0, pop1, take0, take1;
    queue_entry_t     ent0, ent1, first_ent;

    assign hd0_inc = hd0 + 1'b1;
    assign hd1_inc = hd1 + 1'b1;
    assign tl0_inc = tl0 + 1'b1;
    assign tl1_inc = tl1 + 1'b1;

    assign empty0 = (hd0 == tl0);
    assign empty1 = (hd1 == tl1);
    assign full0  = (tl0_inc == hd0);   // one slot sacrificed
    assign full1  = (tl1_inc == hd1);
    assign full   = full0 || full1;

    // words actually entering the queue
    assign v0 = valid0;
    assign v1 = valid1 && !drop1;

    always_comb begin
        ent0.inst    = fetch.inst0;
        ent0.pc      = fetch.pc;
        ent0.pc_next = v1 ? fetch.pc + addr_t'(4) : fetch.pc_next;   // last word takes pc_next
        ent0.exc     = fetch.exc;
        ent1.inst    = fetch.inst1;
        ent1.pc      = fetch.pc + addr_t'(4);
        ent1.pc_next = fetch.pc_next;
        ent1.exc     = fetch.exc;
    end

    assign first_ent = v0 ? ent0 : ent1;   // oldest word of this pair

    assign push_either = v0 ^ v1;
    assign push_both   = v0 && v1;
    assign do_push     = push_valid && !full;

    assign wr0 = do_push && (push_both || (push_either && !push_sel));
    assign wr1 = do_push && (push_both || (push_either && push_sel));

    // two pops take both heads, one pop takes the oldest
    assign pop0  = read_en[1] || (read_en[0] && !pop_sel);
    assign pop1  = read_en[1] || (read_en[0] && pop_sel);
    assign take0 = pop0 && !empty0;
    assign take1 = pop1 && !empty1;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            hd0      <= '0;
            hd1      <= '0;
            tl0      <= '0;
            tl1      <= '0;
            push_sel <= 1'b0;
            pop_sel  <= 1'b0;
        end else begin
            if (take0) hd0 <= hd0_inc;
            if (take1) hd1 <= hd1_inc;
            if (wr0) tl0 <= tl0_inc;
            if (wr1) tl1 <= tl1_inc;
            if (do_push && push_either) push_sel <= ~push_sel;   // odd count shifts order
            if (take0 ^ take1) pop_sel <= ~pop_sel;
        end
    end

    // storage, pointers decide what is live
    always_ff @(posedge clk) begin
        if (wr0) bank0[tl0] <= push_sel ? ent1 : first_ent;
        if (wr1) bank1[tl1] <= push_sel ? first_ent : ent1;
    end

    // heads in program order
    assign head0       = pop_sel ? bank1[hd1] : bank0[hd0];
    assign head1       = pop_sel ? bank0[hd0] : bank1[hd1];
    assign head0_valid = pop_sel ? !empty1 : !empty0;
    assign head1_valid = pop_sel ? !empty0 : !empty1;

endmodule

//--- logic/inst_decoder.sv
`include "id_macros.svh"

module inst_decoder (
    input  id_pkg::queue_entry_t entry,
    input  logic                 entry_valid,
    output id_pkg::decoded_t     out
);
    import id_pkg::*;

    inst_t               inst;
    uop_t                uop;
    logic [`ID_XLEN-1:0] imm;
    logic                illegal;
    logic [`ID_XLEN-1:0] si12, si20, offs16, offs26;
    exc_t                exc;

    assign inst = entry.inst;

    // immediate forms
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign si20   = {inst[24:5], 12'h000};                      // lu12i.w
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};   // b, bl

    always_comb begin
        uop     = UOP_NOP;
        imm     = '0;
        illegal = 1'b0;
        if (inst == `ID_INST_NOP) begin
            uop = UOP_NOP;   // canonical nop, no exception
        end else begin
            casez (inst[31:15])
                17'b00000000000100000: uop = UOP_ADD;
                17'b00000000000100010: uop = UOP_SUB;
                17'b0000001010???????: begin
                    uop = UOP_ADDI;
                    imm = si12;
                end
                17'b0001010??????????: begin
                    uop = UOP_LU12I;
                    imm = si20;
                end
                17'b0010100010???????: begin   // ld.w
                    uop = UOP_LD;
                    imm = si12;
                end
                17'b0010100110???????: begin   // st.w, rd is the data reg
                    uop = UOP_ST;
                    imm = si12;
                end
                17'b010110???????????: begin
                    uop = UOP_BEQ;
                    imm = offs16;
                end
                17'b010111???????????: begin
                    uop = UOP_BNE;
                    imm = offs16;
                end
                17'b010100???????????: begin
                    uop = UOP_B;
                    imm = offs26;
                end
                17'b010101???????????: begin
                    uop = UOP_BL;
                    imm = offs26;
                end
                17'b010011???????????: begin
                    uop = UOP_JIRL;
                    imm = offs16;
                end
                17'b00000000001010110: uop = UOP_SYSCALL;
                17'b00000000001010100: uop = UOP_BREAK;
                default: illegal = 1'b1;   // outside the supported subset
            endcase
        end
    end

    // fetch exception has priority over decode ones
    always_comb begin
        if (entry.exc != `ID_EXC_NONE) exc = entry.exc;
        else if (illegal)              exc = `ID_EXC_INE;
        else if (uop == UOP_SYSCALL)   exc = `ID_EXC_SYS;
        else if (uop == UOP_BREAK)     exc = `ID_EXC_BRK;
        else                           exc = `ID_EXC_NONE;
    end

    always_comb begin
        if (entry_valid) begin
            out.valid   = 1'b1;
            out.uop     = uop;
            out.imm     = imm;
            out.rd      = inst[4:0];
            out.rj      = inst[9:5];
            out.rk      = inst[14:10];
            out.pc      = entry.pc;
            out.pc_next = entry.pc_next;
            out.exc     = exc;
        end else begin
            out.valid   = 1'b0;   // empty slot record
            out.uop     = UOP_NOP;
            out.imm     = '0;
            out.rd      = '0;
            out.rj      = '0;
            out.rk      = '0;
            out.pc      = '0;
            out.pc_next = addr_t'(4);
            out.exc     = `ID_EXC_NONE;
        end
    end

endmodule

//--- logic/id_stage.sv
module id_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  logic                flush,
    input  id_pkg::fetch_pair_t fetch,
    input  logic [1:0]          read_en,   // pop count, 10 unused
    output logic                full,      // stall to fetch
    output id_pkg::decoded_t    slot0,
    output id_pkg::decoded_t    slot1,
    output id_pkg::predict_fb_t feedback,
    output logic                set_pc,
    output id_pkg::addr_t       redirect_pc
);
    import id_pkg::*;

    logic         valid0, valid1, drop1;
    queue_entry_t head0, head1;
    logic         head0_valid, head1_valid;

    // input side, same cycle redirect
    redirect_unit u_redirect (
        .in_valid    (in_valid),
        .fetch       (fetch),
        .set_pc      (set_pc),
        .redirect_pc (redirect_pc),
        .drop1       (drop1),
        .feedback    (feedback),
        .valid0      (valid0),
        .valid1      (valid1)
    );

    fetch_queue u_queue (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .push_valid  (in_valid),
        .valid0      (valid0),
        .valid1      (valid1),
        .drop1       (drop1),
        .fetch       (fetch),
        .read_en     (read_en),
        .full        (full),
        .head0       (head0),
        .head1       (head1),
        .head0_valid (head0_valid),
        .head1_valid (head1_valid)
    );

    // output side, oldest word goes to slot 0
    inst_decoder u_dec0 (
        .entry       (head0),
        .entry_valid (head0_valid),
        .out         (slot0)
    );

    inst_decoder u_dec1 (
        .entry       (head1),
        .entry_valid (head1_valid),
        .out         (slot1)
    );

endmodule

//--- testbench/id_stage_checker.sv
module id_stage_checker (
    input logic              clk,
    input logic              reset,
    input logic              in_valid,
    input logic              flush,
    input logic [1:0]        read_en,
    input logic              full,
    input logic              set_pc,
    input id_pkg::decoded_t  slot0,
    input id_pkg::decoded_t  slot1
);
    import id_pkg::*;

    // stalled push with no pop leaves the queue as it was
    a_full_hold: assert property (@(posedge clk) disable iff (reset)
        full && in_valid && !flush && (read_en == 2'b00)
        |=> full && $stable(slot0) && $stable(slot1))
        else $error("queue contents changed while full");

    a_setpc_valid: assert property (@(posedge clk) disable iff (reset)
        set_pc |-> in_valid)
        else $error("set_pc raised without in_valid");

    // empty slots show the nop record
    a_nop0: assert property (@(posedge clk) disable iff (reset)
        !slot0.valid |-> (slot0.uop == UOP_NOP))
        else $error("invalid slot0 carries a uop");
    a_nop1: assert property (@(posedge clk) disable iff (reset)
        !slot1.valid |-> (slot1.uop == UOP_NOP))
        else $error("invalid slot1 carries a uop");

    a_order: assert property (@(posedge clk) disable iff (reset)
        slot1.valid |-> slot0.valid)   // younger never alone
        else $error("slot1 valid while slot0 empty");

endmodule

bind id_stage id_stage_checker u_checker (.*);

//--- testbench/id_stage_tb.sv
`include "id_macros.svh"

module id_stage_tb;
    import id_pkg::*;

    localparam int MAX_ROWS = 40;
    localparam int PERIOD   = 40;
    // control bits are in_valid, read_en, random read_en and flush
    localparam logic [4:0] C_RUN      = 5'b1_11_0_0;
    localparam logic [4:0] C_IDLE_POP = 5'b0_11_0_0;
    localparam logic [4:0] C_HOLD     = 5'b1_00_0_0;
    localparam logic [4:0] C_POP1     = 5'b1_01_0_0;
    localparam logic [4:0] C_STREAM   = 5'b1_00_1_0;
    localparam logic [4:0] C_DRAIN    = 5'b0_00_1_0;
    localparam logic [4:0] C_FLUSH    = 5'b1_00_0_1;
    localparam logic [4:0] C_QUIET    = 5'b0_00_0_0;
    localparam exc_t       EN         = `ID_EXC_NONE;

    typedef struct packed {
        inst_t   inst;
        uop_t    uop;
        addr_t   imm;
        exc_t    exc;   // decode exception if fetch brings none
        br_cat_t cat;
    } word_t;

    typedef struct packed {
        word_t      w0;
        word_t      w1;
        addr_t      pc;
        addr_t      pc_next;
        logic [2:0] flags;   // unknown0, unknown1, first_jmp
        exc_t       exc;
        logic [4:0] ctl;
        logic [1:0] exp;     // set_pc, slot 1 dropped
        addr_t      rpc;     // expected redirect target
    } row_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        flush;
    fetch_pair_t fetch;
    logic [1:0]  read_en;
    logic        full;
    decoded_t    slot0, slot1;
    predict_fb_t feedback;
    logic        set_pc;
    addr_t       redirect_pc;

    row_t        rows [MAX_ROWS];
    int          n_rows;
    decoded_t    model_q [$];   // expected entries in program order
    int          seq_q [$];     // push order whose parity picks the bank
    int          push_cnt;
    int          errors;
    logic [31:0] lfsr;
    word_t       w_add, w_sub, w_addi, w_lu12i, w_ld, w_st, w_beq_f, w_beq_b;
    word_t       w_bne, w_b, w_bl, w_jirl, w_sys, w_brk, w_ill, w_nop;
    word_t       mix [8];

    id_stage u_dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .flush       (flush),
        .fetch       (fetch),
        .read_en     (read_en),
        .full        (full),
        .slot0       (slot0),
        .slot1       (slot1),
        .feedback    (feedback),
        .set_pc      (set_pc),
        .redirect_pc (redirect_pc)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic next_read_en(output logic [1:0] re);
        logic b0, b1;
        lfsr = lfsr_step(lfsr);
        b0 = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b1 = lfsr[0];
        re = b1 ? 2'b11 : {1'b0, b0};
    endtask

    function automatic word_t mk(input inst_t inst, input uop_t uop, input addr_t imm,
                                 input exc_t exc, input br_cat_t cat);
        word_t w;
        w.inst = inst;
        w.uop  = uop;
        w.imm  = imm;
        w.exc  = exc;
        w.cat  = cat;
        return w;
    endfunction

    function automatic word_t enc_r3(input inst_t base, input uop_t uop,
                                     input reg_idx_t rd, rj, rk);
        return mk(base | {17'b0, rk, rj, rd}, uop, '0, EN, CAT_NONE);
    endfunction

    function automatic word_t enc_i12(input inst_t base, input uop_t uop,
                                      input reg_idx_t rd, rj, input int si);
        logic [31:0] s;
        s = si;
        return mk(base | {10'b0, s[11:0], rj, rd}, uop, s, EN, CAT_NONE);
    endfunction

    // takes a byte offset and encodes a word offset
    function automatic word_t enc_br16(input inst_t base, input uop_t uop, input br_cat_t cat,
                                       input reg_idx_t rd, rj, input int off);
        logic [31:0] o;
        o = off / 4;
        return mk(base | {6'b0, o[15:0], rj, rd}, uop, off, EN, cat);
    endfunction

    function automatic word_t enc_br26(input inst_t base, input uop_t uop, input int off);
        logic [31:0] o;
        o = off / 4;
        return mk(base | {6'b0, o[15:0], o[25:16]}, uop, off, EN, CAT_B);
    endfunction

    task automatic put_row(input word_t w0, w1, input addr_t pc, pc_next,
                           input logic [2:0] flags, input exc_t exc, input logic [4:0] ctl,
                           input logic [1:0] exp, input addr_t rpc);
        row_t r;
        r.w0      = w0;
        r.w1      = w1;
        r.pc      = pc;
        r.pc_next = pc_next;
        r.flags   = flags;
        r.exc     = exc;
        r.ctl     = ctl;
        r.exp     = exp;
        r.rpc     = rpc;
        rows[n_rows] = r;
        n_rows++;
    endtask

    function automatic decoded_t expect_word(input word_t w, input addr_t pc, pc_next,
                                             input exc_t fexc);
        decoded_t d;
        d.valid   = 1'b1;
        d.uop     = w.uop;
        d.imm     = w.imm;
        d.rd      = w.inst[4:0];
        d.rj      = w.inst[9:5];
        d.rk      = w.inst[14:10];
        d.pc      = pc;
        d.pc_next = pc_next;
        d.exc     = (fexc != EN) ? fexc : w.exc;   // fetch exception wins
        return d;
    endfunction

    function automatic decoded_t slot_exp(input int k);
        decoded_t d;
        if (k < model_q.size()) return model_q[k];
        d = '0;
        d.uop     = UOP_NOP;
        d.pc_next = 32'h4;   // empty slot record
        return d;
    endfunction

    function automatic logic model_full();
        int c0, c1;
        c0 = 0;
        c1 = 0;
        foreach (seq_q[i]) begin
            if (seq_q[i] % 2 == 0) c0++;
            else c1++;
        end
        return (c0 == `ID_QDEPTH - 1) || (c1 == `ID_QDEPTH - 1);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            errors++;
            $display("Error %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_slot(input string nm, input decoded_t e, input decoded_t g);
        check_val({nm, ".valid"}, e.valid, g.valid);
        check_val({nm, ".uop"}, e.uop, g.uop);
        check_val({nm, ".imm"}, e.imm, g.imm);
        check_val({nm, ".rd"}, e.rd, g.rd);
        check_val({nm, ".rj"}, e.rj, g.rj);
        check_val({nm, ".rk"}, e.rk, g.rk);
        check_val({nm, ".pc"}, e.pc, g.pc);
        check_val({nm, ".pc_next"}, e.pc_next, g.pc_next);
        check_val({nm, ".exc"}, e.exc, g.exc);
    endtask

    task automatic check_row(input row_t r);
        addr_t off0, off1;
        off0 = (r.w0.cat != CAT_NONE) ? r.w0.imm : '0;   // static targets from the offsets
        off1 = (r.w1.cat != CAT_NONE) ? r.w1.imm : '0;
        check_val("set_pc", r.exp[1], set_pc);
        if (r.exp[1]) check_val("redirect_pc", r.rpc, redirect_pc);
        check_val("feedback.valid", r.ctl[4], feedback.valid);
        check_val("feedback.pc", r.pc, feedback.pc);
        check_val("feedback.target0", r.pc + off0, feedback.target0);
        check_val("feedback.target1", r.pc + 32'h4 + off1, feedback.target1);
        check_val("feedback.cat0", r.w0.cat, feedback.cat0);
        check_val("feedback.cat1", r.w1.cat, feedback.cat1);
        check_val("full", model_full(), full);
        check_slot("slot0", slot_exp(0), slot0);
        check_slot("slot1", slot_exp(1), slot1);
    endtask

    task automatic push_entry(input decoded_t d);
        model_q.push_back(d);
        seq_q.push_back(push_cnt);
        push_cnt++;
    endtask

    // what the coming edge does to the queue
    task automatic update_model(input row_t r, input logic [1:0] re);
        int   n;
        logic v0, v1, was_full;
        was_full = model_full();
        if (r.ctl[0]) begin
            model_q.delete();
            seq_q.delete();
            push_cnt = 0;
        end else begin
            n = re[1] ? 2 : (re[0] ? 1 : 0);
            while (n > 0 && model_q.size() > 0) begin
                void'(model_q.pop_front());
                void'(seq_q.pop_front());
                n--;
            end
            if (r.ctl[4] && !was_full) begin
                v0 = !r.pc[2];
                v1 = !r.flags[0] && !r.exp[0];   // first_jmp or slot 0 redirect
                if (v0) push_entry(expect_word(r.w0, r.pc, v1 ? r.pc + 32'h4 : r.pc_next, r.exc));
                if (v1) push_entry(expect_word(r.w1, r.pc + 32'h4, r.pc_next, r.exc));
            end
        end
    endtask

    task automatic build_table();
        w_add   = enc_r3(32'h0010_0000, UOP_ADD, 5'd1, 5'd2, 5'd3);
        w_sub   = enc_r3(32'h0011_0000, UOP_SUB, 5'd4, 5'd5, 5'd6);
        w_addi  = enc_i12(32'h0280_0000, UOP_ADDI, 5'd7, 5'd8, -3);
        w_lu12i = mk(32'h1400_0000 | {7'b0, 20'h12345, 5'd9}, UOP_LU12I, 32'h1234_5000,
                     EN, CAT_NONE);
        w_ld    = enc_i12(32'h2880_0000, UOP_LD, 5'd10, 5'd11, 16);
        w_st    = enc_i12(32'h2980_0000, UOP_ST, 5'd12, 5'd13, -8);
        w_beq_f = enc_br16(32'h5800_0000, UOP_BEQ, CAT_COND, 5'd1, 5'd2, 16);
        w_beq_b = enc_br16(32'h5800_0000, UOP_BEQ, CAT_COND, 5'd1, 5'd2, -16);
        w_bne   = enc_br16(32'h5c00_0000, UOP_BNE, CAT_COND, 5'd3, 5'd4, 8);
        w_b     = enc_br26(32'h5000_0000, UOP_B, -64);
        w_bl    = enc_br26(32'h5400_0000, UOP_BL, 32'h1000);
        w_jirl  = enc_br16(32'h4c00_0000, UOP_JIRL, CAT_JIRL, 5'd1, 5'd5, 4);
        w_sys   = mk(32'h002b_0005, UOP_SYSCALL, '0, `ID_EXC_SYS, CAT_NONE);
        w_brk   = mk(32'h002a_0001, UOP_BREAK, '0, `ID_EXC_BRK, CAT_NONE);
        w_ill   = mk(32'hffff_ffff, UOP_NOP, '0, `ID_EXC_INE, CAT_NONE);
        w_nop   = mk(`ID_INST_NOP, UOP_NOP, '0, EN, CAT_NONE);
        mix     = '{w_add, w_beq_b, w_ld, w_sys, w_st, w_bne, w_ill, w_lu12i};
        // subset decode with pairs popped as they arrive
        put_row(w_add, w_sub, 32'h1000, 32'h1008, 3'b000, EN, C_RUN, 2'b00, 0);
        put_row(w_addi, w_lu12i, 32'h1008, 32'h1010, 3'b000, EN, C_RUN, 2'b00, 0);
        put_row(w_ld, w_st, 32'h1010, 32'h1018, 3'b000, EN, C_RUN, 2'b00, 0);
        put_row(w_beq_f, w_bne, 32'h1018, 32'h1020, 3'b000, EN, C_RUN, 2'b00, 0);
        put_row(w_b, w_bl, 32'h1020, 32'h1028, 3'b000, EN, C_RUN, 2'b00, 0);   // known
        put_row(w_jirl, w_sys, 32'h1028, 32'h1030, 3'b000, EN, C_RUN, 2'b00, 0);
        put_row(w_brk, w_ill, 32'h1030, 32'h1038, 3'b000, EN, C_RUN, 2'b00, 0);
        put_row(w_ill, w_sys, 32'h1038, 32'h1040, 3'b000, 7'h08, C_RUN, 2'b00, 0);
        put_row(w_add, w_sub, 32'h1044, 32'h104c, 3'b000, EN, C_RUN, 2'b00, 0);   // odd pc
        put_row(w_addi, w_ld, 32'h1050, 32'h2000, 3'b001, EN, C_RUN, 2'b00, 0);
        // static redirects
        put_row(w_beq_b, w_add, 32'h2000, 32'h2008, 3'b100, EN, C_RUN, 2'b11, 32'h1ff0);
        put_row(w_add, w_b, 32'h3000, 32'h3008, 3'b010, EN, C_RUN, 2'b10, 32'h2fc4);
        put_row(w_beq_f, w_jirl, 32'h3008, 32'h3010, 3'b110, EN, C_RUN, 2'b00, 0);
        // both slots jump and the older one wins
        put_row(w_bl, w_b, 32'h3010, 32'h3018, 3'b110, EN, C_RUN, 2'b11, 32'h4010);
        put_row(w_add, w_b, 32'h3018, 32'h3020, 3'b010, EN, C_IDLE_POP, 2'b00, 0);
        // back-pressure with no pops until full
        put_row(w_add, w_sub, 32'h5000, 32'h5008, 3'b000, EN, C_HOLD, 2'b00, 0);
        put_row(w_ld, w_st, 32'h5008, 32'h5010, 3'b000, EN, C_HOLD, 2'b00, 0);
        put_row(w_addi, w_lu12i, 32'h5010, 32'h5018, 3'b000, EN, C_HOLD, 2'b00, 0);
        put_row(w_nop, w_add, 32'h5018, 32'h5020, 3'b000, EN, C_HOLD, 2'b00, 0);
        put_row(w_sub, w_ld, 32'h5020, 32'h5028, 3'b000, EN, C_POP1, 2'b00, 0);
        put_row(w_sub, w_ld, 32'h5020, 32'h5028, 3'b000, EN, C_IDLE_POP, 2'b00, 0);
        for (int k = 0; k < 8; k++) begin   // stream with random pops
            put_row(mix[(2 * k) % 8], mix[(2 * k + 1) % 8], 32'h6000 + 8 * k,
                    32'h6008 + 8 * k, 3'b000, EN, C_STREAM, 2'b00, 0);
        end
        put_row(w_add, w_sub, 32'h6100, 32'h6108, 3'b000, EN, C_DRAIN, 2'b00, 0);
        put_row(w_add, w_sub, 32'h6100, 32'h6108, 3'b000, EN, C_DRAIN, 2'b00, 0);
        put_row(w_ld, w_st, 32'h6200, 32'h6208, 3'b000, EN, C_FLUSH, 2'b00, 0);
        put_row(w_ld, w_st, 32'h6200, 32'h6208, 3'b000, EN, C_QUIET, 2'b00, 0);
        put_row(w_brk, w_sys, 32'h7000, 32'h7008, 3'b000, EN, C_HOLD, 2'b00, 0);
        put_row(w_brk, w_sys, 32'h7000, 32'h7008, 3'b000, EN, C_IDLE_POP, 2'b00, 0);
        put_row(w_brk, w_sys, 32'h7000, 32'h7008, 3'b000, EN, C_QUIET, 2'b00, 0);
    endtask

    initial begin
        row_t        r;
        fetch_pair_t fp;
        logic [1:0]  re;
        errors   = 0;
        n_rows   = 0;
        push_cnt = 0;
        lfsr     = 32'he689;
        reset    <= 1'b1;
        in_valid <= 1'b0;
        flush    <= 1'b0;
        fetch    <= '0;
        read_en  <= 2'b00;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_val("full", 1'b0, full);   // state right after reset
        check_val("set_pc", 1'b0, set_pc);
        check_val("slot0.valid", 1'b0, slot0.valid);
        check_val("slot1.valid", 1'b0, slot1.valid);
        for (int i = 0; i < n_rows; i++) begin
            r = rows[i];
            @(posedge clk);
            if (r.ctl[1]) next_read_en(re);
            else re = r.ctl[3:2];
            fp.inst0     = r.w0.inst;
            fp.inst1     = r.w1.inst;
            fp.pc        = r.pc;
            fp.pc_next   = r.pc_next;
            fp.unknown0  = r.flags[2];
            fp.unknown1  = r.flags[1];
            fp.first_jmp = r.flags[0];
            fp.exc       = r.exc;
            fetch    <= fp;
            in_valid <= r.ctl[4];
            read_en  <= re;
            flush    <= r.ctl[0];
            @(negedge clk);   // combinational outputs settled
            check_row(r);
            update_model(r, re);
        end
        $display("table finished, %0d rows, %0d errors", n_rows, errors);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

    // run length bound from the table rows plus slack
    initial begin
        wait (n_rows > 0);
        #((n_rows + 50) * PERIOD);
        $display("timeout: the stimulus table did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/id_pkg.sv
logic/pre_decoder.sv
logic/redirect_unit.sv
logic/fetch_queue.sv
logic/inst_decoder.sv
logic/id_stage.sv
testbench/id_stage_checker.sv
testbench/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module id_stage_tb -f build.f \
    -o id_stage_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/id_stage_sim)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
